// File: vlog.f
+incdir+logic
logic/iq_pkg.sv
logic/dispatch_stage.sv
logic/tail_ptrs.sv
logic/issue_queue.sv
logic/retire_stage.sv
logic/iq_top.sv
tb/tb_iq_top.sv

// File: Bender.yml
package:
  name: iq_core

sources:
  - include_dirs:
      - logic
    files:
      - logic/iq_pkg.sv
      - logic/dispatch_stage.sv
      - logic/tail_ptrs.sv
      - logic/issue_queue.sv
      - logic/retire_stage.sv
      - logic/iq_top.sv
  - target: test
    include_dirs:
      - logic
    files:
      - tb/tb_iq_top.sv

// File: tb/tb_iq_top.sv
`timescale 1ns/1ps
`include "iq_params.svh"

module tb_iq_top import iq_pkg::*; ();

	localparam int NUM_GROUPS  = 2500;
	localparam int HOLD_LIMIT  = 100;
	localparam int DRAIN_LIMIT = 100;

	logic               clk_i = 1'b0;
	logic               rst_i;
	logic [`QSLOTS-1:0] in_valid;
	tag_t               in_tag0;
	tag_t               in_tag1;
	logic [`QSLOTS-1:0] in_branch;
	logic [`QSLOTS-1:0] in_mispred;
	logic               retire_en;
	logic               in_ready;
	logic               commit_valid;
	tag_t               commit_tag;
	rob_id_t            commit_rid;
	logic               branchmiss;

	integer seed = 56284;

	// reference queue with one element per accepted instruction in acceptance order
	tag_t    m_tag [$];
	rob_id_t m_rid [$];
	logic    m_miss [$];
	rob_id_t next_rid;
	tag_t    tag_ctr;
	logic    pend;
	int      cyc;
	int      flushes;
	int      lone_hi_cnt;
	int      full_stalls;
	int      commits;

	always #4 clk_i = ~clk_i;

	iq_top u_iq_top (.*);

	task automatic abort_run();
		$display("Result: FAILED");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic push_lane(input tag_t tag, input logic br, input logic mp);
		m_tag.push_back(tag);
		m_rid.push_back(next_rid);
		m_miss.push_back(br && mp);
		next_rid = rob_id_t'((next_rid + 1) % `RENTRIES);
	endtask

	// fresh random group whose lane tags come from a running counter
	task automatic new_group();
		in_valid = `QSLOTS'($unsigned($random(seed)) % 4);
		for (int k = 0; k < `QSLOTS; k++) begin
			in_branch[k]  = ($unsigned($random(seed)) % 12) == 0;
			in_mispred[k] = in_branch[k] && (($unsigned($random(seed)) % 3) == 0);
		end
		in_tag0 = tag_ctr;
		in_tag1 = tag_ctr + 1;
		tag_ctr = tag_ctr + 2;
		pend    = (in_valid != '0);
	endtask

	// long stretches with retire_en low let the queue fill up
	task automatic drive_retire(input logic drain);
		if (drain)
			retire_en = 1'b1;
		else if ((cyc % 256) >= 200)
			retire_en = 1'b0;
		else
			retire_en = ($unsigned($random(seed)) % 10) < 6;
		cyc++;
	endtask

	// ============================================================
	// per-cycle check sampled at the falling edge
	// ============================================================

	task automatic check_cycle();
		int      offer;
		logic    exp_miss;
		rob_id_t miss_rid;
		offer    = in_valid[0] + in_valid[1];
		exp_miss = 1'b0;
		miss_rid = '0;
		// a commit here belongs to the pop at the last rising edge
		if (commit_valid) begin
			assert (m_tag.size() != 0) else begin
				$display("a commit appeared while no instruction was outstanding");
				abort_run();
			end
			assert (commit_tag == m_tag[0]) else begin
				$display("ERROR commit_tag got %h expected %h", commit_tag, m_tag[0]);
				abort_run();
			end
			assert (commit_rid == m_rid[0]) else begin
				$display("ERROR commit_rid got %h expected %h", commit_rid, m_rid[0]);
				abort_run();
			end
			exp_miss = m_miss[0];
			miss_rid = m_rid[0];
			m_tag.delete(0);
			m_rid.delete(0);
			m_miss.delete(0);
			commits++;
			// everything younger than a mispredicted branch is thrown away
			if (exp_miss) begin
				m_tag.delete();
				m_rid.delete();
				m_miss.delete();
				next_rid = rob_id_t'((miss_rid + 1) % `RENTRIES);
				flushes++;
			end
		end
		assert (branchmiss == exp_miss) else begin
			$display("ERROR branchmiss got %h expected %h", branchmiss, exp_miss);
			abort_run();
		end
		// model size now equals the queue occupancy seen by dispatch
		if (branchmiss || (m_tag.size() + offer > `IQ_ENTRIES)) begin
			assert (!in_ready) else begin
				$display("ERROR in_ready got %h expected %h", in_ready, 1'b0);
				abort_run();
			end
			if (!branchmiss && offer != 0)
				full_stalls++;
		end else if (offer != 0) begin
			assert (in_ready) else begin
				$display("ERROR in_ready got %h expected %h", in_ready, 1'b1);
				abort_run();
			end
		end
		// the group is taken at the coming rising edge
		if (pend && in_ready) begin
			if (in_valid[0])
				push_lane(in_tag0, in_branch[0], in_mispred[0]);
			if (in_valid[1])
				push_lane(in_tag1, in_branch[1], in_mispred[1]);
			if (in_valid == 2'b10)
				lone_hi_cnt++;
			pend = 1'b0;
		end
	endtask

	// one offer held on the inputs until it is accepted
	task automatic offer_group(input logic drain);
		int hold;
		@(posedge clk_i);
		#1;
		if (drain)
			in_valid = '0;
		else
			new_group();
		drive_retire(drain);
		@(negedge clk_i);
		check_cycle();
		for (hold = 0; pend; hold++) begin
			assert (hold < HOLD_LIMIT) else begin
				$display("an offered group was not accepted within %0d cycles", HOLD_LIMIT);
				abort_run();
			end
			@(posedge clk_i);
			#1;
			drive_retire(1'b0);
			@(negedge clk_i);
			check_cycle();
		end
	endtask

	// ============================================================
	// main sequence
	// ============================================================

	initial begin
		rst_i      = 1'b1;
		in_valid   = '0;
		in_tag0    = '0;
		in_tag1    = '0;
		in_branch  = '0;
		in_mispred = '0;
		retire_en  = 1'b0;
		next_rid   = '0;
		tag_ctr    = '0;
		pend       = 1'b0;
		cyc        = 0;
		flushes    = 0;
		lone_hi_cnt = 0;
		full_stalls = 0;
		commits    = 0;
		repeat (5) @(posedge clk_i);
		#1;
		rst_i = 1'b0;
		assert (!commit_valid && !branchmiss) else begin
			$display("ERROR commit_valid got %h branchmiss got %h expected 0", commit_valid,
				branchmiss);
			abort_run();
		end
		// probe every offer pattern and withdraw it before the next edge
		for (int v = 1; v < 4; v++) begin
			in_valid = `QSLOTS'(v);
			#1;
			assert (in_ready) else begin
				$display("ERROR in_ready got %h expected %h", in_ready, 1'b1);
				abort_run();
			end
		end
		in_valid = '0;

		for (int g = 0; g < NUM_GROUPS; g++) begin
			offer_group(1'b0);
		end

		// with input stopped and retire_en forced high the queue has to empty
		for (int w = 0; m_tag.size() != 0; w++) begin
			assert (w < DRAIN_LIMIT) else begin
				$display("the queue did not drain within %0d cycles", DRAIN_LIMIT);
				abort_run();
			end
			offer_group(1'b1);
		end
		// a stray commit now would hit the empty model check
		repeat (20) offer_group(1'b1);

		assert (flushes > 0 && lone_hi_cnt > 0 && full_stalls > 0 && commits > `RENTRIES)
		else begin
			$display("stimulus missed a flush, a lone lane 1 offer, a full queue or id wrap");
			abort_run();
		end
		$display("Result: PASSED");
		$finish;
	end

endmodule

// File: logic/iq_top.sv
`timescale 1ns/1ps
`include "iq_params.svh"

module iq_top import iq_pkg::*; (
	input  logic               clk_i,
	input  logic               rst_i,
	input  logic [`QSLOTS-1:0] in_valid,
	input  tag_t               in_tag0,
	input  tag_t               in_tag1,
	input  logic [`QSLOTS-1:0] in_branch,
	input  logic [`QSLOTS-1:0] in_mispred,
	input  logic               retire_en,
	output logic               in_ready,
	output logic               commit_valid,
	output tag_t               commit_tag,
	output rob_id_t            commit_rid,
	output logic               branchmiss
);

	// dispatch to queue and tails
	occ_t                   free_cnt;
	logic [`QSLOTS-1:0]     wr_en;
	tag_t                   wr_tag0;
	tag_t                   wr_tag1;
	logic [`QSLOTS-1:0]     wr_branch;
	logic [`QSLOTS-1:0]     wr_mispred;
	cnt_t                   queued_cnt;

	// tails to queue
	iq_idx_t                iq_tails [0:`QSLOTS-1];
	rob_id_t                rob_tails [0:`RSLOTS-1];

	// queue to retire, and the flush going back
	logic                   pop;
	logic                   head_valid;
	tag_t                   head_tag;
	rob_id_t                head_rid;
	logic                   head_branch;
	logic                   head_mispred;
	logic [`IQ_ENTRIES-1:0] iq_valid;
	rob_id_t                iq_rid [0:`IQ_ENTRIES-1];
	logic [`IQ_ENTRIES-1:0] iq_stomp;

	// every block uses the same names for the signals it shares
	dispatch_stage u_dispatch_stage (.*);
	tail_ptrs      u_tail_ptrs (.*);
	issue_queue    u_issue_queue (.*);
	retire_stage   u_retire_stage (.*);

endmodule

// File: logic/retire_stage.sv
`timescale 1ns/1ps
`include "iq_params.svh"

module retire_stage import iq_pkg::*; (
	input  logic                   clk_i,
	input  logic                   rst_i,
	input  logic                   retire_en,
	input  logic                   head_valid,
	input  tag_t                   head_tag,
	input  rob_id_t                head_rid,
	input  logic                   head_branch,
	input  logic                   head_mispred,
	input  logic [`IQ_ENTRIES-1:0] iq_valid,
	output logic                   pop,
	output logic                   commit_valid,
	output tag_t                   commit_tag,
	output rob_id_t                commit_rid,
	output logic                   branchmiss,
	output logic [`IQ_ENTRIES-1:0] iq_stomp
);

	// the entry leaving the queue now is a mispredicted branch
	logic pop_miss;

	// ============================================================
	// pop decision
	// ============================================================

	// retire_en is the consumer's back-pressure
	// the flush cycle never pops, since the head it would see is being stomped
	assign pop = head_valid && retire_en && !branchmiss;

	// both bits are needed, a mispredict flag on a non-branch is ignored
	assign pop_miss = pop && head_branch && head_mispred;

	// ============================================================
	// commit report
	// ============================================================

	// each pop gives exactly one commit pulse on the next cycle
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			commit_valid <= 1'b0;
			branchmiss   <= 1'b0;
		end else begin
			commit_valid <= pop;
			// lines up with the commit of the branch itself
			branchmiss   <= pop_miss;
		end
	end

	// tag and id hold their last value between commits
	always_ff @(posedge clk_i) begin
		if (pop) begin
			commit_tag <= head_tag;
			commit_rid <= head_rid;
		end
	end

	// ============================================================
	// flush
	// ============================================================

	// the branch is already gone from the queue, so every valid entry left is
	// younger than it and gets stomped
	assign iq_stomp = branchmiss ? iq_valid : '0;

endmodule

// File: logic/issue_queue.sv
`timescale 1ns/1ps
`include "iq_params.svh"

module issue_queue import iq_pkg::*; (
	input  logic                   clk_i,
	input  logic                   rst_i,
	input  logic [`QSLOTS-1:0]     wr_en,
	input  tag_t                   wr_tag0,
	input  tag_t                   wr_tag1,
	input  logic [`QSLOTS-1:0]     wr_branch,
	input  logic [`QSLOTS-1:0]     wr_mispred,
	input  iq_idx_t                iq_tails [0:`QSLOTS-1],
	input  rob_id_t                rob_tails [0:`RSLOTS-1],
	input  logic                   pop,
	input  logic                   branchmiss,
	input  logic [`IQ_ENTRIES-1:0] iq_stomp,
	output occ_t                   free_cnt,
	output logic                   head_valid,
	output tag_t                   head_tag,
	output rob_id_t                head_rid,
	output logic                   head_branch,
	output logic                   head_mispred,
	output logic [`IQ_ENTRIES-1:0] iq_valid,
	output rob_id_t                iq_rid [0:`IQ_ENTRIES-1]
);

	// entry payload
	tag_t                   q_tag [0:`IQ_ENTRIES-1];
	rob_id_t                q_rid [0:`IQ_ENTRIES-1];
	logic [`IQ_ENTRIES-1:0] q_branch;
	logic [`IQ_ENTRIES-1:0] q_mispred;

	// entry state and ring bookkeeping
	logic [`IQ_ENTRIES-1:0] q_valid;
	iq_idx_t                head;
	occ_t                   occ;

	// per-slot view of the write tags
	tag_t                   wr_tag [0:`QSLOTS-1];
	logic [`IQ_ENTRIES-1:0] valid_nxt;
	occ_t                   wr_cnt;
	occ_t                   stomp_cnt;

	assign wr_tag[0] = wr_tag0;
	assign wr_tag[1] = wr_tag1;

	// ============================================================
	// next valid vector and occupancy terms
	// ============================================================

	always_comb begin
		wr_cnt    = '0;
		stomp_cnt = '0;
		valid_nxt = q_valid;
		for (int k = 0; k < `QSLOTS; k++) begin
			if (wr_en[k]) begin
				valid_nxt[iq_tails[k]] = 1'b1;
				wr_cnt = wr_cnt + occ_t'(1);
			end
		end
		// a pop never meets a write on the same slot, a full queue takes no writes
		if (pop) begin
			valid_nxt[head] = 1'b0;
		end
		// stomp is all zero outside a miss cycle
		for (int n = 0; n < `IQ_ENTRIES; n++) begin
			stomp_cnt = stomp_cnt + occ_t'(iq_stomp[n]);
		end
		valid_nxt = valid_nxt & ~iq_stomp;
	end

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			q_valid <= '0;
			head    <= '0;
			occ     <= '0;
		end else begin
			q_valid <= valid_nxt;
			occ     <= occ + wr_cnt - occ_t'(pop) - stomp_cnt;
			// the head stays put on a flush, the tails rewind onto it
			if (pop) begin
				head <= head + iq_idx_t'(1);
			end
		end
	end

	// each dispatch slot lands at its own tail with its own id
	always_ff @(posedge clk_i) begin
		for (int k = 0; k < `QSLOTS; k++) begin
			if (wr_en[k]) begin
				q_tag[iq_tails[k]]     <= wr_tag[k];
				q_rid[iq_tails[k]]     <= rob_tails[k];
				q_branch[iq_tails[k]]  <= wr_branch[k];
				q_mispred[iq_tails[k]] <= wr_mispred[k];
			end
		end
	end

	// ============================================================
	// outputs
	// ============================================================

	// no room is offered while the flush is in progress
	assign free_cnt = branchmiss ? '0 : occ_t'(`IQ_ENTRIES) - occ;

	assign head_valid   = q_valid[head];
	assign head_tag     = q_tag[head];
	assign head_rid     = q_rid[head];
	assign head_branch  = q_branch[head];
	assign head_mispred = q_mispred[head];

	assign iq_valid = q_valid;
	assign iq_rid   = q_rid;

endmodule

// File: logic/tail_ptrs.sv
`timescale 1ns/1ps
`include "iq_params.svh"

module tail_ptrs import iq_pkg::*; (
	input  logic                   clk_i,
	input  logic                   rst_i,
	input  logic                   branchmiss,
	input  logic [`IQ_ENTRIES-1:0] iq_stomp,
	input  cnt_t                   queued_cnt,
	input  rob_id_t                iq_rid [0:`IQ_ENTRIES-1],
	output iq_idx_t                iq_tails [0:`QSLOTS-1],
	output rob_id_t                rob_tails [0:`RSLOTS-1]
);

	// first slot of the stomped run, its predecessor is not stomped
	iq_idx_t rw_slot;
	// some slot was stomped, so there is something to rewind to
	logic    rw_found;

	// the stomp vector is one contiguous run on the ring, so at most one
	// slot satisfies the start condition
	always_comb begin
		rw_slot  = '0;
		rw_found = 1'b0;
		for (int n = 0; n < `IQ_ENTRIES; n++) begin
			// adding IQ_ENTRIES-1 steps back one slot without going negative
			if (iq_stomp[n] && !iq_stomp[(n + `IQ_ENTRIES - 1) % `IQ_ENTRIES]) begin
				rw_slot  = iq_idx_t'(n);
				rw_found = 1'b1;
			end
		end
	end

	// ============================================================
	// tail update
	// ============================================================

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			// consecutive slots and ids starting from zero
			for (int n = 0; n < `QSLOTS; n++) begin
				iq_tails[n] <= iq_idx_t'(n);
			end
			for (int n = 0; n < `RSLOTS; n++) begin
				rob_tails[n] <= rob_id_t'(n);
			end
		end else if (!branchmiss) begin
			// the same dispatch count moves both the slots and the ids
			for (int n = 0; n < `QSLOTS; n++) begin
				iq_tails[n] <= iq_idx_t'((iq_tails[n] + queued_cnt) % `IQ_ENTRIES);
			end
			for (int n = 0; n < `RSLOTS; n++) begin
				rob_tails[n] <= rob_id_t'((rob_tails[n] + queued_cnt) % `RENTRIES);
			end
		end else if (rw_found) begin
			// reload from the oldest stomped entry and the id it was given
			for (int j = 0; j < `QSLOTS; j++) begin
				iq_tails[j] <= iq_idx_t'((rw_slot + j) % `IQ_ENTRIES);
			end
			for (int j = 0; j < `RSLOTS; j++) begin
				rob_tails[j] <= rob_id_t'((iq_rid[rw_slot] + j) % `RENTRIES);
			end
		end
		// a miss with nothing stomped leaves the tails on the head already
	end

endmodule

// File: logic/dispatch_stage.sv
`timescale 1ns/1ps
`include "iq_params.svh"

// purely combinational producer side of the issue queue
// clock and reset only keep the port list the same as the other stages
module dispatch_stage import iq_pkg::*; (
	input  logic               clk_i,
	input  logic               rst_i,
	input  logic [`QSLOTS-1:0] in_valid,
	input  tag_t               in_tag0,
	input  tag_t               in_tag1,
	input  logic [`QSLOTS-1:0] in_branch,
	input  logic [`QSLOTS-1:0] in_mispred,
	input  occ_t               free_cnt,
	output logic               in_ready,
	output logic [`QSLOTS-1:0] wr_en,
	output tag_t               wr_tag0,
	output tag_t               wr_tag1,
	output logic [`QSLOTS-1:0] wr_branch,
	output logic [`QSLOTS-1:0] wr_mispred,
	output cnt_t               queued_cnt
);

	// lanes offered this cycle, whether or not they are taken
	cnt_t offer_cnt;
	// group goes into the queue at the next edge
	logic accept;
	// only the upper lane holds an instruction
	logic lone_hi;

	always_comb begin
		offer_cnt = '0;
		for (int k = 0; k < `QSLOTS; k++) begin
			offer_cnt = offer_cnt + cnt_t'(in_valid[k]);
		end
	end

	// ============================================================
	// handshake
	// ============================================================

	// free space must cover every offered lane
	// a zero free count (full queue or flush cycle) always reads as not ready
	assign in_ready = (free_cnt != '0) && (free_cnt >= occ_t'(offer_cnt));
	assign accept   = in_ready && (offer_cnt != '0);

	// the tail pointers only advance by a count, so slots must fill from slot 0 up
	assign lone_hi = in_valid[1] && !in_valid[0];

	// slot 0 is written by any accepted group, slot 1 only by a full pair
	assign wr_en[0] = accept;
	assign wr_en[1] = accept && (offer_cnt == cnt_t'(2));

	// ============================================================
	// lane compaction
	// ============================================================

	// a lone lane 1 instruction moves down into slot 0
	assign wr_tag0       = lone_hi ? in_tag1 : in_tag0;
	assign wr_branch[0]  = lone_hi ? in_branch[1] : in_branch[0];
	assign wr_mispred[0] = lone_hi ? in_mispred[1] : in_mispred[0];

	// slot 1 is only ever fed from lane 1
	assign wr_tag1       = in_tag1;
	assign wr_branch[1]  = in_branch[1];
	assign wr_mispred[1] = in_mispred[1];

	// zero unless the group is actually taken
	assign queued_cnt = accept ? offer_cnt : '0;

endmodule

// File: logic/iq_pkg.sv
`include "iq_params.svh"

package iq_pkg;

	// slot index into the issue queue ring
	typedef logic [$clog2(`IQ_ENTRIES)-1:0] iq_idx_t;
	// reorder-buffer id, wide enough for the whole id range
	typedef logic [$clog2(`RENTRIES)-1:0] rob_id_t;
	// opaque instruction tag, only carried and reported
	typedef logic [`TAG_W-1:0] tag_t;
	// number of instructions dispatched on one clock, 0 up to QSLOTS
	typedef logic [$clog2(`QSLOTS+1)-1:0] cnt_t;
	// queue occupancy or free space, 0 up to IQ_ENTRIES
	typedef logic [$clog2(`IQ_ENTRIES+1)-1:0] occ_t;

endpackage

// File: logic/iq_params.svh
`ifndef IQ_PARAMS_SVH
`define IQ_PARAMS_SVH

// number of issue queue entries, the ring wraps at this value
`define IQ_ENTRIES 8

// instructions the dispatch stage may accept on one clock
`define QSLOTS 2

// reorder-buffer id range, ids count modulo this value
`define RENTRIES 16

// reorder-buffer ids claimed per clock, same as the dispatch width
`define RSLOTS 2

// width of the instruction tag carried through to commit
`define TAG_W 8

`endif
